//--- project.f
hdl/buffer_cfg_pkg.sv
hdl/stream_pkg.sv
hdl/block_ram.sv
hdl/fifo_ctrl.sv
hdl/credit_issuer.sv
hdl/stream_buffer.sv
tb/stream_buffer_sva.sv
tb/stream_buffer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the stream buffer testbench with Verilator and runs it
# the run fails when the log holds the testbench's fail message

cd "$(dirname "$0")" || exit 1

TOP=stream_buffer_tb
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module "$TOP" \
	-f project.f \
	-o "$TOP" \
	|| { echo "verilator build error"; exit 1; }

./obj_dir/"$TOP" > "$LOG" 2>&1 \
	|| echo "simulation exited with a nonzero status" >> "$LOG"

cat "$LOG"

grep -q "test failed" "$LOG" && { echo "FAIL: see $LOG"; exit 1; }
grep -q "test passed" "$LOG" || { echo "FAIL: no pass message in $LOG"; exit 1; }
echo "PASS"
exit 0

//--- tb/stream_buffer_tb.sv
`timescale 1ns/1ps

/*
 * testbench for the credit-flow stream buffer
 * models a credited upstream, checks words against a reference queue
 * and counts the credits that come back
 */

module stream_buffer_tb;

localparam int DEPTH = buffer_cfg_pkg::DEPTH;
localparam int CLK_HALF = 20;
localparam int RESET_CYCLES = 10;
localparam int CREDIT_BEATS = 8;
localparam int BP_BEATS = 4;
localparam int BP_HOLD = 6;
localparam int MIX_BEATS = 200;
localparam int TOTAL_BEATS = DEPTH + CREDIT_BEATS + BP_BEATS + MIX_BEATS;
localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 8 + 200;

logic                  clk;
logic                  reset;
stream_pkg::in_beat_t  in_beat;
stream_pkg::credit_t   credit;
stream_pkg::out_beat_t out_beat;
logic                  out_ready;

integer seed;

// upstream credit model and scoreboard
int credits_held;
int credits_total;
int reads_total;
int sent_total;
buffer_cfg_pkg::word_t ref_q[$];

stream_buffer DUT (
	.clk(clk),
	.reset(reset),
	.in_beat(in_beat),
	.credit(credit),
	.out_beat(out_beat),
	.out_ready(out_ready)
);

initial clk = 1'b0;
always #CLK_HALF clk = ~clk;

task automatic stop_run();
	$display("test failed");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic report_error(input string what);
	$display("ERROR at %0t: %s", $time, what);
	stop_run();
endtask

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
		stop_run();
	end
endtask

function automatic bit chance(input int percent);
	int r;
	r = $random(seed) & 32'h7fff_ffff;
	return (r % 100) < percent;
endfunction

// runs at the falling edge, where all DUT outputs are settled
task automatic observe();
	if (credit) begin
		credits_held++;
		credits_total++;
	end
	if (out_beat.valid && out_ready) begin
		if (ref_q.size() == 0) begin
			report_error("a word was read although none was waiting");
		end
		check_value("out_beat.data", 32'(out_beat.data), 32'(ref_q.pop_front()));
		reads_total++;
	end
	if (credits_held + ref_q.size() > DEPTH) begin
		report_error("more credits granted than free entries in the buffer");
	end
endtask

// one clock cycle, a beat goes out only if upstream holds a credit
task automatic step(input bit want_send, input bit ready);
	bit send;
	buffer_cfg_pkg::word_t data;
	send = want_send && (credits_held > 0);
	data = buffer_cfg_pkg::word_t'($random(seed));
	@(posedge clk);
	#1;
	in_beat.valid = send;
	in_beat.data = send ? data : '0;
	out_ready = ready;
	if (send) begin
		credits_held--;
		sent_total++;
		ref_q.push_back(data);
	end
	@(negedge clk);
	observe();
endtask

task automatic apply_reset();
	reset = 1'b1;
	repeat (RESET_CYCLES - 1) begin
		@(negedge clk);
		check_value("out_beat.valid", 32'(out_beat.valid), 32'd0);
		check_value("credit", 32'(credit), 32'd0);
	end
	@(posedge clk);
	#1;
	reset = 1'b0;
endtask

task automatic drain_all();
	while (ref_q.size() != 0) begin
		step(1'b0, 1'b1);
	end
endtask

task automatic settle_credits(input int limit);
	int waited;
	waited = 0;
	while (credits_total != DEPTH + reads_total) begin
		if (waited >= limit) begin
			report_error("credits for completed reads were not returned in time");
		end
		step(1'b0, 1'b0);
		waited++;
	end
endtask

task automatic test_reset_credits();
	// first credit arrives in the first cycle with reset low
	@(negedge clk);
	observe();
	check_value("credit", 32'(credit), 32'd1);
	check_value("out_beat.valid", 32'(out_beat.valid), 32'd0);
	for (int i = 1; i < DEPTH; i++) begin
		step(1'b0, 1'b0);
		check_value("credit", 32'(credit), 32'd1);
		check_value("out_beat.valid", 32'(out_beat.valid), 32'd0);
	end
	repeat (2 * DEPTH) begin
		step(1'b0, 1'b0);
		check_value("credit", 32'(credit), 32'd0);
		check_value("out_beat.valid", 32'(out_beat.valid), 32'd0);
	end
endtask

task automatic test_fill_drain();
	int start_credits;
	for (int i = 0; i < DEPTH; i++) begin
		step(1'b1, 1'b0);
	end
	// full and stalled, so nothing comes back
	start_credits = credits_total;
	repeat (DEPTH) begin
		step(1'b0, 1'b0);
	end
	check_value("credits_total", 32'(credits_total), 32'(start_credits));
	drain_all();
	settle_credits(2 * DEPTH);
endtask

// back-to-back writes keep the offer down until the burst ends
task automatic test_credit_return();
	for (int i = 0; i < CREDIT_BEATS; i++) begin
		step(1'b1, 1'b1);
	end
	drain_all();
	settle_credits(DEPTH + CREDIT_BEATS);
endtask

task automatic test_back_pressure();
	int waited;
	waited = 0;
	for (int i = 0; i < BP_BEATS; i++) begin
		step(1'b1, 1'b0);
	end
	while (!out_beat.valid) begin
		if (waited >= 8) begin
			report_error("out_beat.valid did not rise after the writes stopped");
		end
		step(1'b0, 1'b0);
		waited++;
	end
	repeat (BP_HOLD) begin
		step(1'b0, 1'b0);
		check_value("out_beat.valid", 32'(out_beat.valid), 32'd1);
		check_value("out_beat.data", 32'(out_beat.data), 32'(ref_q[0]));
		check_value("credit", 32'(credit), 32'd0);
	end
	drain_all();
	settle_credits(DEPTH + BP_BEATS);
endtask

task automatic test_mixed_traffic();
	int start_sent;
	start_sent = sent_total;
	while (sent_total - start_sent < MIX_BEATS) begin
		step(chance(40), chance(75));
	end
	drain_all();
	settle_credits(DEPTH + MIX_BEATS);
endtask

initial begin
	repeat (TIMEOUT_CYCLES) @(posedge clk);
	report_error("watchdog expired, the DUT stopped moving data or credits");
end

initial begin
	seed = 32'hfef2f886;
	reset = 1'b1;
	in_beat = '0;
	out_ready = 1'b0;
	credits_held = 0;
	credits_total = 0;
	reads_total = 0;
	sent_total = 0;

	apply_reset();
	test_reset_credits();
	test_fill_drain();
	test_credit_return();
	test_back_pressure();
	test_mixed_traffic();

	$display("test passed");
	$finish;
end

endmodule

//--- tb/stream_buffer_sva.sv
`timescale 1ns/1ps

/*
 * stream buffer assertions
 * FIFO control and credit invariants, bound into fifo_ctrl and credit_issuer
 */

module stream_buffer_sva (
	input logic                   clk,
	input logic                   reset,
	input logic                   ram_we,
	input logic                   full,
	input logic                   out_valid,
	input buffer_cfg_pkg::word_t  out_data,
	input buffer_cfg_pkg::count_t owed
);

// credits keep upstream from writing into a full buffer
no_write_when_full: assert property (@(posedge clk) disable iff (reset) ram_we |-> !full)
	else $error("write into the FIFO while it is full");

// the write took the RAM port, so the head word is not on the RAM output yet
no_valid_after_write: assert property (@(posedge clk) disable iff (reset)
	ram_we |=> !out_valid)
	else $error("out valid rose in the cycle after a write");

// an offered word holds until it is taken
stable_offer: assert property (@(posedge clk) disable iff (reset)
	(out_valid && $past(out_valid)) |-> $stable(out_data))
	else $error("out data changed while out valid stayed high");

owed_in_range: assert property (@(posedge clk) disable iff (reset)
	owed <= buffer_cfg_pkg::DEPTH_COUNT)
	else $error("owed credit count exceeds the FIFO depth");

endmodule

// control side, the owed count lives in the credit issuer
bind fifo_ctrl stream_buffer_sva ctrl_sva (
	.clk(clk),
	.reset(reset),
	.ram_we(ram_we),
	.full(full),
	.out_valid(out_beat.valid),
	.out_data(out_beat.data),
	.owed('0)
);

// credit side, no RAM port here
bind credit_issuer stream_buffer_sva credit_sva (
	.clk(clk),
	.reset(reset),
	.ram_we(1'b0),
	.full(1'b0),
	.out_valid(1'b0),
	.out_data('0),
	.owed(owed)
);

//--- hdl/stream_buffer.sv
`timescale 1ns/1ps

/*
 * credit-flow stream buffer
 * upstream writes against credits, downstream reads with valid/ready,
 * the words sit in a single-port block RAM FIFO
 */

module stream_buffer (
	input  logic                  clk,
	input  logic                  reset,

	// upstream
	input  stream_pkg::in_beat_t  in_beat,
	output stream_pkg::credit_t   credit,

	// downstream
	output stream_pkg::out_beat_t out_beat,
	input  logic                  out_ready
);

// RAM port
buffer_cfg_pkg::addr_t ram_addr;
buffer_cfg_pkg::word_t ram_wdata;
buffer_cfg_pkg::word_t ram_rdata;
logic                  ram_we;

// read transfer strobe into the credit path
logic read_done;

fifo_ctrl u_ctrl (
	.clk(clk),
	.reset(reset),
	.in_beat(in_beat),
	.ram_addr(ram_addr),
	.ram_wdata(ram_wdata),
	.ram_we(ram_we),
	.ram_rdata(ram_rdata),
	.out_beat(out_beat),
	.out_ready(out_ready),
	.read_done(read_done)
);

block_ram u_ram (
	.clk(clk),
	.addr(ram_addr),
	.wdata(ram_wdata),
	.we(ram_we),
	.rdata(ram_rdata)
);

credit_issuer u_credit (
	.clk(clk),
	.reset(reset),
	.read_done(read_done),
	.credit(credit)
);

endmodule

//--- hdl/credit_issuer.sv
`timescale 1ns/1ps

/*
 * credit issuer
 * counts credits owed to upstream, DEPTH after reset plus one per read,
 * and pays them out as single-cycle pulses, at most one per cycle
 */

module credit_issuer (
	input  logic                clk,
	input  logic                reset,

	// one pulse per word leaving the buffer
	input  logic                read_done,

	// one pulse per granted credit
	output stream_pkg::credit_t credit
);

// credits not yet scheduled for upstream
buffer_cfg_pkg::count_t owed;
buffer_cfg_pkg::count_t owed_next;

// a credit goes out in every cycle where something is owed
logic issue;

assign issue = (owed != '0);

// low through reset, the first DEPTH pulses start as soon as reset drops
assign credit = issue && !reset;

// a new read and an issued credit in the same cycle cancel out
always_comb begin
	owed_next = owed;

	if (read_done && !issue) begin
		owed_next = owed + 1'b1;
	end else if (!read_done && issue) begin
		owed_next = owed - 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		owed <= buffer_cfg_pkg::DEPTH_COUNT;
	end else begin
		owed <= owed_next;
	end
end

endmodule

//--- hdl/fifo_ctrl.sv
`timescale 1ns/1ps

/*
 * FIFO control for the credit-flow stream buffer
 * owns the pointers and fill state, gives writes the single RAM port
 * and refetches the head word for the downstream offer after a write
 */

module fifo_ctrl (
	input  logic                  clk,
	input  logic                  reset,

	// upstream, credited so there is no ready
	input  stream_pkg::in_beat_t  in_beat,

	// RAM port
	output buffer_cfg_pkg::addr_t ram_addr,
	output buffer_cfg_pkg::word_t ram_wdata,
	output logic                  ram_we,
	input  buffer_cfg_pkg::word_t ram_rdata,

	// downstream
	output stream_pkg::out_beat_t out_beat,
	input  logic                  out_ready,

	// one pulse per read transfer, for the credit issuer
	output logic                  read_done
);

buffer_cfg_pkg::addr_t wr_ptr;
buffer_cfg_pkg::addr_t rd_ptr;
buffer_cfg_pkg::addr_t wr_ptr_next;
buffer_cfg_pkg::addr_t rd_ptr_next;

buffer_cfg_pkg::rd_state_t rd_state;
buffer_cfg_pkg::rd_state_t rd_state_next;

logic has_data;
logic wr_en;
logic rd_xfer;
logic empty;
logic full;

// upstream only sends while it holds a credit, so every beat is accepted
assign wr_en = in_beat.valid;
assign rd_xfer = out_beat.valid && out_ready;

// equal pointers mean either empty or full, has_data tells them apart
assign empty = !has_data;
assign full = has_data && (wr_ptr == rd_ptr);

assign wr_ptr_next = (wr_ptr == buffer_cfg_pkg::LAST_ADDR) ? '0 : wr_ptr + 1'b1;
assign rd_ptr_next = (rd_ptr == buffer_cfg_pkg::LAST_ADDR) ? '0 : rd_ptr + 1'b1;

// a write takes the port, otherwise the head address is presented
// so the RAM output holds the head word one cycle later
assign ram_we = wr_en;
assign ram_addr = wr_en ? wr_ptr : rd_ptr;
assign ram_wdata = in_beat.data;

// offer comes straight from the RAM output register
assign out_beat.valid = (rd_state == buffer_cfg_pkg::RD_PRESENT);
assign out_beat.data = ram_rdata;

assign read_done = rd_xfer;

// pointers and fill state
always_ff @(posedge clk) begin
	if (reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		has_data <= 1'b0;
	end else begin
		if (wr_en) begin
			wr_ptr <= wr_ptr_next;
		end

		if (rd_xfer) begin
			rd_ptr <= rd_ptr_next;
		end

		// a concurrent write always leaves at least one word behind
		if (wr_en) begin
			has_data <= 1'b1;
		end else if (rd_xfer && (rd_ptr_next == wr_ptr)) begin
			has_data <= 1'b0;
		end
	end
end

// offer state
// going present needs a cycle where the port read the head address,
// i.e. a nonempty cycle without a write
always_comb begin
	rd_state_next = rd_state;

	case (rd_state)
		buffer_cfg_pkg::RD_IDLE: begin
			if (!empty && !wr_en) begin
				rd_state_next = buffer_cfg_pkg::RD_PRESENT;
			end
		end

		buffer_cfg_pkg::RD_PRESENT: begin
			// a read moves the head, a write overwrites the RAM output
			if (rd_xfer || wr_en) begin
				rd_state_next = buffer_cfg_pkg::RD_IDLE;
			end
		end

		default: begin
			rd_state_next = buffer_cfg_pkg::RD_IDLE;
		end
	endcase
end

always_ff @(posedge clk) begin
	if (reset) begin
		rd_state <= buffer_cfg_pkg::RD_IDLE;
	end else begin
		rd_state <= rd_state_next;
	end
end

endmodule

//--- hdl/block_ram.sv
`timescale 1ns/1ps

/*
 * single-port synchronous block RAM
 * one address per cycle, read data follows the address by one cycle,
 * a write cycle returns the old contents (read-before-write)
 */

module block_ram (
	input  logic                  clk,
	input  buffer_cfg_pkg::addr_t addr,
	input  buffer_cfg_pkg::word_t wdata,
	input  logic                  we,
	output buffer_cfg_pkg::word_t rdata
);

// storage array
buffer_cfg_pkg::word_t mem [buffer_cfg_pkg::DEPTH];

// the read samples the array before this edge's write lands
always_ff @(posedge clk) begin
	rdata <= mem[addr];

	if (we) begin
		mem[addr] <= wdata;
	end
end

endmodule

//--- hdl/stream_pkg.sv
/*
 * stream interface types
 * upstream beat, downstream offer and the credit pulse returned upstream
 */

package stream_pkg;

// one upstream transfer, only legal while upstream holds a credit
typedef struct packed {
	logic                  valid;
	buffer_cfg_pkg::word_t data;
} in_beat_t;

// downstream offer, a transfer needs valid together with out_ready
typedef struct packed {
	logic                  valid;
	buffer_cfg_pkg::word_t data;
} out_beat_t;

// high for one cycle per granted credit
typedef logic credit_t;

endpackage

//--- hdl/buffer_cfg_pkg.sv
/*
 * stream buffer configuration
 * sizes, width types and the read-state encoding that the storage,
 * the FIFO control and the credit issuer agree on
 */

package buffer_cfg_pkg;

// number of stored words, also the credits granted after reset
localparam int DEPTH = 16;

// pointer width, DEPTH must fit exactly
localparam int ADDR_WIDTH = 4;

// payload word width
localparam int DATA_WIDTH = 16;

// count width, one bit wider than the pointer so it can hold DEPTH
localparam int CNT_WIDTH = 5;

// one stored word
typedef logic [DATA_WIDTH-1:0] word_t;

// RAM address or FIFO pointer
typedef logic [ADDR_WIDTH-1:0] addr_t;

// credits owed to upstream
typedef logic [CNT_WIDTH-1:0] count_t;

// last address before the pointers wrap
localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

// reset value of the owed-credit counter
localparam count_t DEPTH_COUNT = count_t'(DEPTH);

// downstream offer state, RD_PRESENT means the head word is on out_beat
typedef enum logic {
	RD_IDLE,
	RD_PRESENT
} rd_state_t;

endpackage
